// File: Makefile
SIM = obj_dir/Vtb_spi
SRC = $(wildcard verilog/*.sv bench/*.sv bench/*.svh)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRC)
	verilator --binary --top-module tb_spi -f tb.f

clean:
	rm -rf obj_dir

// File: bench/tb_spi_util.svh
/* testbench helpers: LFSR random source, expected control word,
   expected chip selects, compare tasks */
`ifndef TB_SPI_UTIL_SVH
`define TB_SPI_UTIL_SVH
`default_nettype none

// ----------------------------------------------------------------------
// random source, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // shift left, feedback in
endfunction

function automatic spi_word_t rand_bits(int n);
    spi_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v      = {v[30:0], lfsr_q[15]};               // one step per bit taken
        lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
endfunction

// ----------------------------------------------------------------------
// expected control/status word from last write and FIFO fill levels
function automatic spi_word_t exp_ctrl(spi_word_t wr_val, int tx_n, int rx_n);
    spi_word_t w;
    w = wr_val & spi_ctrl_wmask;                      // writable part as written
    w[spi_ctrl_rx_avail] = (rx_n != 0);
    w[spi_ctrl_tx_empty] = (tx_n == 0);
    w[spi_ctrl_tx_nhalf] = (2 * tx_n < FIFO_DEPTH);   // below half full
    w[spi_ctrl_tx_full]  = (tx_n == FIFO_DEPTH);
    w[spi_ctrl_fifo_msb:spi_ctrl_fifo_lsb] = 4'($clog2(FIFO_DEPTH));
    w[spi_ctrl_busy]     = (tx_n != 0);               // engine idle once settled
    return w;
endfunction

// one line low only with enable and cs_en
function automatic spi_byte_t csn_for(spi_word_t v);
    if (v[spi_ctrl_en] && v[spi_ctrl_cs_en])
        return ~(8'h01 << v[spi_ctrl_cs_sel_msb:spi_ctrl_cs_sel_lsb]);
    return 8'hFF;
endfunction

// ----------------------------------------------------------------------
task automatic check_word(string name, spi_word_t got, spi_word_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_byte(string name, spi_byte_t got, spi_byte_t exp);
    if (got !== exp) begin
        $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

`default_nettype wire
`endif

// File: bench/tb_spi.sv
/* SPI controller testbench: clock and reset, bus tasks, loopback in
   all four modes, chip select and interrupt stimulus, checker, watchdog */
`timescale 1ns/10ps
`default_nettype none

module tb_spi import spi_regs_pkg::*, spi_phy_pkg::*; ();

    localparam int FIFO_DEPTH      = 4;
    localparam int BURST           = FIFO_DEPTH;      // fills rx FIFO, never overruns
    localparam int N_BURSTS        = 3;               // per cpol/cpha mode
    localparam int TOTAL_BYTES     = 4 * N_BURSTS * BURST + 2;
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 17 * 16 + 2000;

    logic       clk_i;
    logic       rstn_i;
    spi_addr_t  addr_i;
    logic       wren_i;
    logic       rden_i;
    spi_word_t  data_i;
    spi_word_t  data_o;
    logic       ack_o;
    logic       spi_clk_o;
    wire        spi_dat;                              // mosi looped to miso
    logic [7:0] spi_csn_o;
    logic       irq_o;

    logic [15:0] lfsr_q;                              // random state
    spi_byte_t   tx_q [$];                            // written, not yet sent
    spi_byte_t   rx_q [$];                            // sent, not yet read
    logic        model_cpol;                          // idle level in use
    logic        count_edges;
    logic        clk_prev;
    int          departures;                          // spi_clk_o leaving idle

    // results waiting for the checker
    spi_word_t word_got [$];
    spi_word_t word_exp [$];
    string     word_name [$];
    spi_byte_t byte_got [$];
    spi_byte_t byte_exp [$];
    string     byte_name [$];

    spi_top #(.FIFO_DEPTH(FIFO_DEPTH)) spi_top_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (addr_i),
        .wren_i    (wren_i),
        .rden_i    (rden_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .ack_o     (ack_o),
        .spi_clk_o (spi_clk_o),
        .spi_dat_o (spi_dat),
        .spi_dat_i (spi_dat),
        .spi_csn_o (spi_csn_o),
        .irq_o     (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                   // 40 ns period
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    // ------------------------------------------------------------------
    // bus access, driven on the falling edge, ends on ack_o
    task automatic bus_write(spi_addr_t a, spi_word_t d);
        int cycles;
        @(negedge clk_i);
        addr_i = a;
        data_i = d;
        wren_i = 1'b1;
        @(negedge clk_i);
        wren_i = 1'b0;
        cycles = 1;
        while (!ack_o) begin
            @(negedge clk_i);
            cycles++;
        end
        expect_byte("ack_o write latency", spi_byte_t'(cycles), 8'd1);
    endtask

    task automatic bus_read(spi_addr_t a, output spi_word_t d);
        int cycles;
        @(negedge clk_i);
        addr_i = a;
        rden_i = 1'b1;
        @(negedge clk_i);
        rden_i = 1'b0;
        cycles = 1;
        while (!ack_o) begin
            expect_word("data_o", data_o, 32'h0);     // zero outside ack
            @(negedge clk_i);
            cycles++;
        end
        expect_byte("ack_o read latency", spi_byte_t'(cycles), 8'd2);
        d = data_o;                                   // valid with ack
    endtask

    task automatic expect_word(string name, spi_word_t got, spi_word_t exp);
        word_name.push_back(name);
        word_got.push_back(got);
        word_exp.push_back(exp);
    endtask

    task automatic expect_byte(string name, spi_byte_t got, spi_byte_t exp);
        byte_name.push_back(name);
        byte_got.push_back(got);
        byte_exp.push_back(exp);
    endtask

    task automatic send_byte(spi_byte_t b);
        bus_write(spi_data_addr, spi_word_t'(b));
        tx_q.push_back(b);
    endtask

    task automatic read_byte();
        spi_word_t rd;
        bus_read(spi_data_addr, rd);
        expect_word("data_o", rd, spi_word_t'(rx_q.pop_front()));
    endtask

    task automatic verify_ctrl(spi_word_t ctrl_v);
        spi_word_t rd;
        bus_read(spi_ctrl_addr, rd);
        expect_word("ctrl", rd, exp_ctrl(ctrl_v, tx_q.size(), rx_q.size()));
    endtask

    // two idle reads in a row, a single one may fall between bytes
    task automatic wait_idle();
        spi_word_t st;
        int        zeros;
        zeros = 0;
        while (zeros < 2) begin
            bus_read(spi_ctrl_addr, st);
            zeros = st[spi_ctrl_busy] ? 0 : zeros + 1;
        end
        while (tx_q.size() > 0) rx_q.push_back(tx_q.pop_front()); // all sent
    endtask

    // ------------------------------------------------------------------
    // checker: drains queued results, counts clock departures
    initial begin
        forever begin
            @(negedge clk_i);
            if (count_edges && clk_prev == model_cpol && spi_clk_o != model_cpol)
                departures++;
            clk_prev = spi_clk_o;
            while (word_got.size() > 0)
                check_word(word_name.pop_front(), word_got.pop_front(), word_exp.pop_front());
            while (byte_got.size() > 0)
                check_byte(byte_name.pop_front(), byte_got.pop_front(), byte_exp.pop_front());
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    // ------------------------------------------------------------------
    initial begin
        spi_word_t ctrl_v;
        rstn_i      = 1'b0;
        addr_i      = '0;
        wren_i      = 1'b0;
        rden_i      = 1'b0;
        data_i      = '0;
        lfsr_q      = 16'd33301;
        model_cpol  = 1'b0;
        count_edges = 1'b0;
        clk_prev    = 1'b0;
        departures  = 0;
        repeat (16) @(negedge clk_i);
        rstn_i = 1'b1;

        verify_ctrl(32'h0);                           // status bits only
        expect_byte("spi_csn_o", spi_csn_o, 8'hFF);
        expect_byte("irq_o", {7'b0, irq_o}, 8'h00);

        // control readback, then fixed chip select cases
        for (int i = 0; i < 11; i++) begin
            case (i)
                8:       ctrl_v = 32'h0000_006D;      // enable, cs_en, line 5
                9:       ctrl_v = 32'h0000_0001;      // cs_en cleared
                10:      ctrl_v = 32'h0000_0068;      // enable cleared
                default: ctrl_v = rand_bits(32);
            endcase
            bus_write(spi_ctrl_addr, ctrl_v);
            verify_ctrl(ctrl_v);
            expect_byte("spi_csn_o", spi_csn_o, csn_for(ctrl_v));
        end

        // loopback bursts in every mode
        for (int m = 0; m < 4; m++) begin
            for (int b = 0; b < N_BURSTS; b++) begin
                ctrl_v = spi_word_t'(1) | (spi_word_t'(m) << spi_ctrl_cpha)
                       | (rand_bits(4) << spi_ctrl_cdiv_lsb);
                model_cpol = m[1];
                bus_write(spi_ctrl_addr, ctrl_v);
                repeat (2) @(negedge clk_i);          // clock settles at rest
                expect_byte("spi_clk_o", {7'b0, spi_clk_o}, {7'b0, model_cpol});
                departures  = 0;
                count_edges = 1'b1;
                for (int k = 0; k < BURST; k++) send_byte(spi_byte_t'(rand_bits(8)));
                wait_idle();
                count_edges = 1'b0;
                expect_word("spi_clk_o departures", spi_word_t'(departures),
                            spi_word_t'(8 * BURST));
                expect_byte("spi_clk_o", {7'b0, spi_clk_o}, {7'b0, model_cpol});
                verify_ctrl(ctrl_v);
                for (int k = 0; k < BURST; k++) read_byte();
                verify_ctrl(ctrl_v);                  // rx drained, busy clear
            end
        end

        // rx data interrupt
        ctrl_v = spi_word_t'(1) | (spi_word_t'(1) << spi_ctrl_irq_rx_avail);
        bus_write(spi_ctrl_addr, ctrl_v);
        verify_ctrl(ctrl_v);
        expect_byte("irq_o", {7'b0, irq_o}, 8'h00);
        send_byte(8'hA5);
        wait_idle();
        verify_ctrl(ctrl_v);
        expect_byte("irq_o", {7'b0, irq_o}, 8'h01);
        read_byte();
        verify_ctrl(ctrl_v);
        expect_byte("irq_o", {7'b0, irq_o}, 8'h00);   // fell with rx empty

        // tx empty interrupt
        ctrl_v = spi_word_t'(1) | (spi_word_t'(1) << spi_ctrl_irq_tx_empty);
        bus_write(spi_ctrl_addr, ctrl_v);
        verify_ctrl(ctrl_v);
        expect_byte("irq_o", {7'b0, irq_o}, 8'h01);

        // disable flushes the FIFOs and masks the interrupt
        ctrl_v = ctrl_v | (spi_word_t'(1) << spi_ctrl_irq_rx_avail);
        bus_write(spi_ctrl_addr, ctrl_v);
        send_byte(8'h3C);
        wait_idle();
        verify_ctrl(ctrl_v);
        ctrl_v[spi_ctrl_en] = 1'b0;
        bus_write(spi_ctrl_addr, ctrl_v);
        tx_q.delete();
        rx_q.delete();
        verify_ctrl(ctrl_v);                          // rx_avail back to 0
        expect_byte("irq_o", {7'b0, irq_o}, 8'h00);

        repeat (2) @(negedge clk_i);                  // checker drains last results
        if (word_got.size() == 0 && byte_got.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("results were left unchecked at the end of the run");
            abort_run();
        end
    end

`include "tb_spi_util.svh"

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
verilog/spi_regs_pkg.sv
verilog/spi_phy_pkg.sv
verilog/spi_fifo_if.sv
verilog/spi_fifo.sv
verilog/spi_ctrl_regs.sv
verilog/spi_engine.sv
verilog/spi_top.sv
bench/tb_spi.sv

// File: verilog/spi_ctrl_regs.sv
/* register block: control register, status read mux, data register
   access to the FIFOs, chip select decode and interrupt */
`timescale 1ns/10ps
`default_nettype none

module spi_ctrl_regs import spi_regs_pkg::*, spi_phy_pkg::*; #(
    parameter int FIFO_DEPTH = 4                      // reported as log2
) (
    input  wire          clk_i,
    input  wire          rstn_i,
    input  spi_addr_t    addr_i,
    input  wire          wren_i,                      // single cycle write
    input  wire          rden_i,                      // single cycle read
    input  spi_word_t    data_i,
    output spi_word_t    data_o,                      // zero outside ack
    output logic         ack_o,
    output spi_ctrl_t    ctrl_o,
    input  wire          busy_i,                      // engine mid-byte
    spi_fifo_if.producer tx_if,
    spi_fifo_if.consumer rx_if,
    output logic [7:0]   spi_csn_o,                   // active low selects
    output logic         irq_o
);

    localparam int FIFO_LOG2 = $clog2(FIFO_DEPTH);

    logic      rden_q;                                // read strobe, one cycle late
    spi_addr_t rd_addr_q;                             // address of pending read
    spi_word_t ctrl_word;                             // assembled control/status

    // ------------------------------------------------------------------
    // control register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ctrl_o <= '0;
        end else if (wren_i && (addr_i == spi_ctrl_addr)) begin
            ctrl_o.enable       <= data_i[spi_ctrl_en];
            ctrl_o.cpha         <= data_i[spi_ctrl_cpha];
            ctrl_o.cpol         <= data_i[spi_ctrl_cpol];
            ctrl_o.cs_sel       <= data_i[spi_ctrl_cs_sel_msb:spi_ctrl_cs_sel_lsb];
            ctrl_o.cs_en        <= data_i[spi_ctrl_cs_en];
            ctrl_o.cdiv         <= data_i[spi_ctrl_cdiv_msb:spi_ctrl_cdiv_lsb];
            ctrl_o.irq_rx_avail <= data_i[spi_ctrl_irq_rx_avail];
            ctrl_o.irq_tx_empty <= data_i[spi_ctrl_irq_tx_empty];
        end
    end

    // data register goes straight to the FIFOs
    assign tx_if.push  = wren_i & (addr_i == spi_data_addr);
    assign tx_if.wdata = spi_byte_t'(data_i[7:0]);
    assign rx_if.pop   = rden_i & (addr_i == spi_data_addr);

    // status view
    always_comb begin
        ctrl_word = '0;
        ctrl_word[spi_ctrl_en]                             = ctrl_o.enable;
        ctrl_word[spi_ctrl_cpha]                           = ctrl_o.cpha;
        ctrl_word[spi_ctrl_cpol]                           = ctrl_o.cpol;
        ctrl_word[spi_ctrl_cs_sel_msb:spi_ctrl_cs_sel_lsb] = ctrl_o.cs_sel;
        ctrl_word[spi_ctrl_cs_en]                          = ctrl_o.cs_en;
        ctrl_word[spi_ctrl_cdiv_msb:spi_ctrl_cdiv_lsb]     = ctrl_o.cdiv;
        ctrl_word[spi_ctrl_rx_avail]                       = rx_if.avail;
        ctrl_word[spi_ctrl_tx_empty]                       = ~tx_if.avail;
        ctrl_word[spi_ctrl_tx_nhalf]                       = ~tx_if.half;
        ctrl_word[spi_ctrl_tx_full]                        = ~tx_if.free;
        ctrl_word[spi_ctrl_irq_rx_avail]                   = ctrl_o.irq_rx_avail;
        ctrl_word[spi_ctrl_irq_tx_empty]                   = ctrl_o.irq_tx_empty;
        ctrl_word[spi_ctrl_fifo_msb:spi_ctrl_fifo_lsb]     = 4'(FIFO_LOG2);
        ctrl_word[spi_ctrl_busy]                           = busy_i | tx_if.avail;
    end

    // ------------------------------------------------------------------
    // bus response, reads wait one cycle for the rx FIFO read port
    always_ff @(posedge clk_i) begin
        if (rden_i) rd_addr_q <= addr_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rden_q <= 1'b0;
            ack_o  <= 1'b0;
            data_o <= '0;
        end else begin
            rden_q <= rden_i;
            ack_o  <= rden_q | wren_i;                // write +1, read +2
            if (!rden_q) data_o <= '0;
            else if (rd_addr_q == spi_ctrl_addr) data_o <= ctrl_word;
            else data_o <= spi_word_t'(rx_if.rdata);  // zero extended byte
        end
    end

    // ------------------------------------------------------------------
    // chip select and interrupt
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            spi_csn_o <= '1;
            irq_o     <= 1'b0;
        end else begin
            spi_csn_o <= '1;                          // all released
            if (ctrl_o.cs_en && ctrl_o.enable) spi_csn_o[ctrl_o.cs_sel] <= 1'b0;
            irq_o <= ctrl_o.enable &
                     ((ctrl_o.irq_rx_avail & rx_if.avail) |
                      (ctrl_o.irq_tx_empty & ~tx_if.avail));
        end
    end

endmodule

`default_nettype wire

// File: verilog/spi_engine.sv
/* serial engine: half bit divider and shift FSM for all four
   cpol/cpha modes, MSB first, tx FIFO in and rx FIFO out */
`timescale 1ns/10ps
`default_nettype none

module spi_engine import spi_regs_pkg::*, spi_phy_pkg::*; (
    input  wire          clk_i,
    input  wire          rstn_i,
    input  spi_ctrl_t    ctrl_i,
    spi_fifo_if.consumer tx_if,
    spi_fifo_if.producer rx_if,
    output logic         busy_o,                      // byte in flight
    output logic         spi_clk_o,
    output logic         spi_dat_o,
    input  wire          spi_dat_i
);

    spi_cdiv_t  cdiv_cnt;                             // divider counter
    logic       tick;                                 // one per half bit
    spi_state_e state;
    logic       start_q;                              // pop seen, rdata next
    spi_byte_t  sreg;                                 // shift register
    logic [3:0] bitcnt;                               // bits sampled so far
    logic       sdi_q;                                // sampled input bit
    logic       done_q;                               // byte complete

    // ------------------------------------------------------------------
    // half bit divider, tick every cdiv+1 cycles
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cdiv_cnt <= '0;
            tick     <= 1'b0;
        end else if (!ctrl_i.enable) begin
            cdiv_cnt <= '0;                           // restart on enable
            tick     <= 1'b0;
        end else if (cdiv_cnt == spi_cdiv_t'(ctrl_i.cdiv)) begin
            cdiv_cnt <= '0;
            tick     <= 1'b1;
        end else begin
            cdiv_cnt <= cdiv_cnt + 1'b1;
            tick     <= 1'b0;
        end
    end

    // fetch next byte only when idle and no fetch in progress
    assign tx_if.pop = (state == st_idle) & tx_if.avail & ~start_q;

    // ------------------------------------------------------------------
    // shift FSM
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state     <= st_off;
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            spi_clk_o <= 1'b0;
            sreg      <= '0;
            bitcnt    <= '0;
            sdi_q     <= 1'b0;
        end else begin
            start_q <= tx_if.pop;
            done_q  <= 1'b0;
            if (!ctrl_i.enable) begin
                state     <= st_off;                  // abort any byte
                spi_clk_o <= ctrl_i.cpol;
                sreg      <= '0;
            end else begin
                case (state)
                    st_off: begin
                        spi_clk_o <= ctrl_i.cpol;
                        sreg      <= '0;
                        state     <= st_idle;
                    end
                    st_idle: begin
                        spi_clk_o <= ctrl_i.cpol;     // rest level
                        bitcnt    <= '0;
                        if (start_q) begin
                            sreg  <= tx_if.rdata;     // first bit on line now
                            state <= st_lead;
                        end
                    end
                    st_lead: begin
                        if (tick) begin
                            if (ctrl_i.cpha) spi_clk_o <= ~ctrl_i.cpol; // leading edge early
                            state <= st_phase1;
                        end
                    end
                    st_phase1: begin
                        if (tick) begin
                            spi_clk_o <= ~(ctrl_i.cpha ^ ctrl_i.cpol);
                            sdi_q     <= spi_dat_i;   // sample
                            bitcnt    <= bitcnt + 1'b1;
                            state     <= st_phase2;
                        end
                    end
                    st_phase2: begin
                        if (tick) begin
                            sreg <= {sreg[6:0], sdi_q}; // next bit out, sample in
                            if (bitcnt[3]) begin
                                spi_clk_o <= ctrl_i.cpol;
                                done_q    <= 1'b1;
                                state     <= st_idle;
                            end else begin
                                spi_clk_o <= ctrl_i.cpha ^ ctrl_i.cpol;
                                state     <= st_phase1;
                            end
                        end
                    end
                    default: state <= st_off;
                endcase
            end
        end
    end

    // received byte out, lost if rx FIFO is full
    assign rx_if.push  = done_q;
    assign rx_if.wdata = sreg;

    assign busy_o    = (state == st_lead) | (state == st_phase1) | (state == st_phase2);
    assign spi_dat_o = sreg[7];                       // MSB first

endmodule

`default_nettype wire

// File: verilog/spi_fifo.sv
/* byte ring buffer with registered read, fill level flags and
   clear while the core is disabled */
`timescale 1ns/10ps
`default_nettype none

module spi_fifo import spi_phy_pkg::*, spi_regs_pkg::*; #(
    parameter int FIFO_DEPTH = 4                      // power of two, 1..32768
) (
    input  wire       clk_i,
    input  wire       rstn_i,
    input  spi_ctrl_t ctrl_i,                         // only enable used
    spi_fifo_if.store fifo
);

    localparam int PW       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW       = $clog2(FIFO_DEPTH + 1);
    localparam int HALF_LVL = (FIFO_DEPTH + 1) / 2;

    spi_byte_t         mem [FIFO_DEPTH];              // storage
    logic [PW-1:0]     wr_ptr, rd_ptr;
    logic [CW-1:0]     count;                         // fill level
    logic              we, re;

    assign we = fifo.push & fifo.free;                // drop when full
    assign re = fifo.pop & fifo.avail;                // ignore when empty

    // pointers and level
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!ctrl_i.enable) begin
            wr_ptr <= '0;                             // flush
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (we) wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (re) rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (we && !re) count <= count + 1'b1;
            else if (re && !we) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we) mem[wr_ptr] <= fifo.wdata;
        if (re) fifo.rdata <= mem[rd_ptr];            // valid next cycle
    end

    assign fifo.avail = (count != '0);
    assign fifo.free  = (count != CW'(FIFO_DEPTH));
    assign fifo.half  = (count >= CW'(HALF_LVL));

endmodule

`default_nettype wire

// File: verilog/spi_fifo_if.sv
/* FIFO link between a producer, a consumer and the buffer itself */
`timescale 1ns/10ps
`default_nettype none

interface spi_fifo_if import spi_phy_pkg::*; ();

    logic      push;                                  // write strobe
    spi_byte_t wdata;                                 // write byte
    logic      pop;                                   // read strobe
    spi_byte_t rdata;                                 // read byte, cycle after pop
    logic      avail;                                 // at least one entry
    logic      free;                                  // at least one slot open
    logic      half;                                  // half full or more

    modport producer (
        output push, wdata,
        input  free, avail, half
    );

    modport consumer (
        output pop,
        input  rdata, avail
    );

    modport store (
        input  push, wdata, pop,
        output rdata, avail, free, half
    );

endinterface

`default_nettype wire

// File: verilog/spi_phy_pkg.sv
/* serial side types: byte, divider counter and engine states */
`default_nettype none

package spi_phy_pkg;

    typedef logic [7:0] spi_byte_t;                   // one serial frame
    typedef logic [3:0] spi_cdiv_t;                   // half bit divider

    // engine sequence, one half bit per tick after st_lead
    typedef enum logic [2:0] {
        st_off,                                       // core disabled
        st_idle,                                      // waiting for tx data
        st_lead,                                      // lead-in half bit
        st_phase1,                                    // sample edge
        st_phase2                                     // shift edge
    } spi_state_e;

endpackage

`default_nettype wire

// File: verilog/spi_regs_pkg.sv
/* SPI controller register map: bus word and address types, register
   addresses, control word bit positions, writable mask, control struct */
`default_nettype none

package spi_regs_pkg;

    typedef logic [31:0] spi_word_t;                  // bus data word
    typedef logic [0:0]  spi_addr_t;                  // word address

    localparam spi_addr_t spi_ctrl_addr = 1'b0;       // control/status
    localparam spi_addr_t spi_data_addr = 1'b1;       // tx push / rx pop

    // ------------------------------------------------------------------
    // control word bit positions
    localparam int spi_ctrl_en           = 0;         // r/w core enable
    localparam int spi_ctrl_cpha         = 1;         // r/w clock phase
    localparam int spi_ctrl_cpol         = 2;         // r/w clock polarity
    localparam int spi_ctrl_cs_sel_lsb   = 3;         // r/w chip select index
    localparam int spi_ctrl_cs_sel_msb   = 5;
    localparam int spi_ctrl_cs_en        = 6;         // r/w drive selected cs low
    localparam int spi_ctrl_cdiv_lsb     = 10;        // r/w half bit divider
    localparam int spi_ctrl_cdiv_msb     = 13;
    localparam int spi_ctrl_rx_avail     = 16;        // r/- rx fifo not empty
    localparam int spi_ctrl_tx_empty     = 17;        // r/- tx fifo empty
    localparam int spi_ctrl_tx_nhalf     = 18;        // r/- tx fifo below half
    localparam int spi_ctrl_tx_full      = 19;        // r/- tx fifo full
    localparam int spi_ctrl_irq_rx_avail = 20;        // r/w irq on rx data
    localparam int spi_ctrl_irq_tx_empty = 21;        // r/w irq on tx empty
    localparam int spi_ctrl_fifo_lsb     = 23;        // r/- log2 of fifo depth
    localparam int spi_ctrl_fifo_msb     = 26;
    localparam int spi_ctrl_busy         = 31;        // r/- engine or tx pending

    localparam spi_word_t spi_ctrl_wmask = 32'h0030_3C7F; // writable bits only

    // writable part of the control register
    typedef struct packed {
        logic       irq_tx_empty;
        logic       irq_rx_avail;
        logic [3:0] cdiv;
        logic       cs_en;
        logic [2:0] cs_sel;
        logic       cpol;
        logic       cpha;
        logic       enable;
    } spi_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/spi_top.sv
/* SPI controller top: register block, tx and rx FIFOs, serial engine */
`timescale 1ns/10ps
`default_nettype none

module spi_top import spi_regs_pkg::*; #(
    parameter int FIFO_DEPTH = 4                      // power of two, 1..32768
) (
    input  wire        clk_i,
    input  wire        rstn_i,                        // async, active low
    input  spi_addr_t  addr_i,
    input  wire        wren_i,
    input  wire        rden_i,
    input  spi_word_t  data_i,
    output spi_word_t  data_o,
    output logic       ack_o,
    output logic       spi_clk_o,
    output logic       spi_dat_o,                     // controller out
    input  wire        spi_dat_i,                     // controller in
    output logic [7:0] spi_csn_o,
    output logic       irq_o
);

    spi_ctrl_t ctrl;                                  // live control fields
    logic      busy;                                  // engine mid-byte

    spi_fifo_if tx_if ();                             // regs -> engine
    spi_fifo_if rx_if ();                             // engine -> regs

    // ------------------------------------------------------------------
    spi_ctrl_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) spi_ctrl_regs_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .addr_i    (addr_i),
        .wren_i    (wren_i),
        .rden_i    (rden_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .ack_o     (ack_o),
        .ctrl_o    (ctrl),
        .busy_i    (busy),
        .tx_if     (tx_if),
        .rx_if     (rx_if),
        .spi_csn_o (spi_csn_o),
        .irq_o     (irq_o)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .ctrl_i (ctrl),
        .fifo   (tx_if)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .ctrl_i (ctrl),
        .fifo   (rx_if)
    );

    spi_engine spi_engine_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ctrl_i    (ctrl),
        .tx_if     (tx_if),
        .rx_if     (rx_if),
        .busy_o    (busy),
        .spi_clk_o (spi_clk_o),
        .spi_dat_o (spi_dat_o),
        .spi_dat_i (spi_dat_i)
    );

endmodule

`default_nettype wire
